// ==== Bender.yml ====
package:
  name: upsp

sources:
  - source/upsp_pix_pkg.sv
  - source/upsp_ctl_pkg.sv
  - source/upsp_col_counter.sv
  - source/upsp_line_fsm.sv
  - source/upsp_interp.sv
  - source/upsp_lane_fifo.sv
  - source/upsp_outbuf.sv
  - source/upsp_top.sv
  - target: test
    files:
      - tests/tb_upsp.sv

// ==== sim.f ====
source/upsp_pix_pkg.sv
source/upsp_ctl_pkg.sv
source/upsp_col_counter.sv
source/upsp_line_fsm.sv
source/upsp_interp.sv
source/upsp_lane_fifo.sv
source/upsp_outbuf.sv
source/upsp_top.sv
tests/tb_upsp.sv

// ==== source/upsp_col_counter.sv ====
/* Source column and row counter */

`timescale 1ns/1ns

module upsp_col_counter (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                accept,
    output upsp_pix_pkg::col_t  col,
    output upsp_pix_pkg::row_t  row,
    output logic                is_last_col,
    output logic                is_last_frame_col
);

    logic is_last_row;

    assign is_last_col       = (col == upsp_pix_pkg::col_t'(upsp_pix_pkg::SRC_WIDTH - 1));
    assign is_last_row       = (row == upsp_pix_pkg::row_t'(upsp_pix_pkg::SRC_HEIGHT - 1));
    assign is_last_frame_col = is_last_col & is_last_row;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            col <= '0;
            row <= '0;
        end else if (accept) begin
            if (is_last_col) begin
                col <= '0;
                // Next row, or back to the top of the frame
                if (is_last_row)
                    row <= '0;
                else
                    row <= row + 1'b1;
            end else begin
                col <= col + 1'b1;
            end
        end
    end

endmodule

// ==== source/upsp_ctl_pkg.sv ====
/* Line control and buffer types */

package upsp_ctl_pkg;

    // Entries in each lane FIFO, a power of two
    localparam int LANE_DEPTH = 8;

    // Extra bit separates full from empty
    typedef logic [$clog2(LANE_DEPTH):0] lane_ptr_t;

    // Position within a source row
    typedef enum logic [1:0] {
        LINE_HEAD,
        LINE_BODY,
        LINE_TAIL
    } line_state_t;

    // Write data into the buffer, one pixel per lane
    typedef struct packed {
        upsp_pix_pkg::pix_t [upsp_pix_pkg::N_LANES-1:0] lane;
    } beat_t;

endpackage

// ==== source/upsp_interp.sv ====
/* Interpolation and beat assembly */

`timescale 1ns/1ns

module upsp_interp (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      accept,
    input  logic                      tail,
    input  upsp_ctl_pkg::line_state_t state,
    input  upsp_pix_pkg::col_t        col,
    input  upsp_pix_pkg::pix_t        pix_in,
    input  logic                      buf_wready,
    output logic                      beat_valid,
    output logic                      beat_pending,
    output upsp_ctl_pkg::beat_t       beat
);

    upsp_pix_pkg::pix_t  prev1_q;
    upsp_pix_pkg::pix_t  prev2_q;
    upsp_ctl_pkg::beat_t beat_nxt;
    logic                load;
    logic                pend_q;

    // Per-channel mean, 9-bit sum dropped by one bit
    function automatic upsp_pix_pkg::pix_t avg_pix(input upsp_pix_pkg::pix_t a,
                                                   input upsp_pix_pkg::pix_t b);
        logic [8:0]         sum_r;
        logic [8:0]         sum_g;
        logic [8:0]         sum_b;
        upsp_pix_pkg::pix_t res;
        sum_r = {1'b0, a.r} + {1'b0, b.r};
        sum_g = {1'b0, a.g} + {1'b0, b.g};
        sum_b = {1'b0, a.b} + {1'b0, b.b};
        res.r = sum_r[8:1];
        res.g = sum_g[8:1];
        res.b = sum_b[8:1];
        return res;
    endfunction

    // Odd columns close a beat, even ones are only stored
    assign load = tail | (accept & col[0]);

    always_comb begin
        beat_nxt = '0;
        if (tail) begin
            // Last source pixel repeated at the row end
            beat_nxt.lane[2] = prev1_q;
            beat_nxt.lane[3] = prev1_q;
        end else if (state == upsp_ctl_pkg::LINE_HEAD) begin
            beat_nxt.lane[0] = prev1_q;
            beat_nxt.lane[1] = avg_pix(prev1_q, pix_in);
        end else begin
            beat_nxt.lane[2] = prev2_q;
            beat_nxt.lane[3] = avg_pix(prev2_q, prev1_q);
            beat_nxt.lane[0] = prev1_q;
            beat_nxt.lane[1] = avg_pix(prev1_q, pix_in);
        end
    end

    // Source history
    always_ff @(posedge clk) begin
        if (accept) begin
            prev2_q <= prev1_q;
            prev1_q <= pix_in;
        end
        if (load)
            beat <= beat_nxt;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            pend_q <= 1'b0;
        else if (load)
            pend_q <= 1'b1;
        else if (buf_wready)
            pend_q <= 1'b0;
    end

    assign beat_valid   = pend_q;
    assign beat_pending = pend_q;

endmodule

// ==== source/upsp_lane_fifo.sv ====
/* Single-pixel lane FIFO */

`timescale 1ns/1ns

module upsp_lane_fifo (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               wr,
    input  logic               rd,
    input  upsp_pix_pkg::pix_t wdata,
    output upsp_pix_pkg::pix_t rdata,
    output logic               empty,
    output logic               full
);

    upsp_pix_pkg::pix_t      mem [upsp_ctl_pkg::LANE_DEPTH];
    upsp_ctl_pkg::lane_ptr_t wr_ptr_q;
    upsp_ctl_pkg::lane_ptr_t rd_ptr_q;
    upsp_ctl_pkg::lane_ptr_t rd_ptr_nxt;
    logic                    do_wr;
    logic                    do_rd;

    assign do_wr      = wr & ~full;
    assign do_rd      = rd & ~empty;
    assign rd_ptr_nxt = rd_ptr_q + upsp_ctl_pkg::lane_ptr_t'(do_rd);

    // Pointers a whole depth apart
    assign full = (wr_ptr_q - rd_ptr_q) ==
                  upsp_ctl_pkg::lane_ptr_t'(upsp_ctl_pkg::LANE_DEPTH);

    // Head entry shown without a read
    assign rdata = mem[rd_ptr_q[$bits(upsp_ctl_pkg::lane_ptr_t)-2:0]];

    always_ff @(posedge clk) begin
        if (do_wr)
            mem[wr_ptr_q[$bits(upsp_ctl_pkg::lane_ptr_t)-2:0]] <= wdata;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            empty    <= 1'b1;
        end else begin
            if (do_wr)
                wr_ptr_q <= wr_ptr_q + 1'b1;
            rd_ptr_q <= rd_ptr_nxt;
            // Compared against the write pointer from before this edge,
            // so a new entry shows up one edge late
            empty <= (wr_ptr_q == rd_ptr_nxt);
        end
    end

endmodule

// ==== source/upsp_line_fsm.sv ====
/* Row sequencing FSM */

`timescale 1ns/1ns

module upsp_line_fsm (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      pix_valid,
    input  logic                      beat_pending,
    input  logic                      buf_wready,
    input  logic                      is_last_col,
    input  upsp_pix_pkg::col_t        col,
    output logic                      accept,
    output logic                      pix_ready,
    output logic                      tail,
    output upsp_ctl_pkg::line_state_t state
);

    upsp_ctl_pkg::line_state_t state_nxt;
    logic                      run_q;
    logic                      stall;

    // Pending beat that cannot leave this cycle
    assign stall     = beat_pending & ~buf_wready;
    assign pix_ready = run_q & ~stall & (state != upsp_ctl_pkg::LINE_TAIL);
    assign accept    = pix_valid & pix_ready;

    // Tail beat goes out once the pending register frees up
    assign tail = (state == upsp_ctl_pkg::LINE_TAIL) & ~stall;

    always_comb begin
        state_nxt = state;
        case (state)
            upsp_ctl_pkg::LINE_HEAD: begin
                if (accept && col == upsp_pix_pkg::col_t'(1))
                    state_nxt = upsp_ctl_pkg::LINE_BODY;
            end
            upsp_ctl_pkg::LINE_BODY: begin
                if (accept && is_last_col)
                    state_nxt = upsp_ctl_pkg::LINE_TAIL;
            end
            upsp_ctl_pkg::LINE_TAIL: begin
                if (tail)
                    state_nxt = upsp_ctl_pkg::LINE_HEAD;
            end
            default: state_nxt = upsp_ctl_pkg::LINE_HEAD;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= upsp_ctl_pkg::LINE_HEAD;
            run_q <= 1'b0;
        end else begin
            state <= state_nxt;
            // Input held off until the first edge out of reset
            run_q <= 1'b1;
        end
    end

endmodule

// ==== source/upsp_outbuf.sv ====
/* Four-lane output buffer */

`timescale 1ns/1ns

module upsp_outbuf (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 beat_valid,
    input  upsp_ctl_pkg::beat_t  beat,
    output logic                 buf_wready,
    input  logic                 rd,
    output upsp_pix_pkg::word_t  rd_word,
    output logic                 buf_empty
);

    upsp_pix_pkg::dst_col_t          dst_col_q;
    upsp_pix_pkg::dst_col_t          step;
    logic [upsp_pix_pkg::N_LANES-1:0] wr_mask;
    logic [upsp_pix_pkg::N_LANES-1:0] lane_empty;
    logic [upsp_pix_pkg::N_LANES-1:0] lane_full;
    upsp_pix_pkg::pix_t              lane_rdata [upsp_pix_pkg::N_LANES];
    logic                            wr_go;
    logic                            rd_go;

    assign buf_wready = ~(|lane_full);
    assign buf_empty  = |lane_empty;
    assign wr_go      = beat_valid & buf_wready;
    assign rd_go      = rd & ~buf_empty;

    // Row head and row tail beats carry two pixels
    always_comb begin
        if (dst_col_q == '0)
            wr_mask = 4'b0011;
        else if (dst_col_q == upsp_pix_pkg::dst_col_t'(upsp_pix_pkg::DST_WIDTH - 2))
            wr_mask = 4'b1100;
        else
            wr_mask = '1;
    end

    assign step = upsp_pix_pkg::dst_col_t'($countones(wr_mask));

    // Destination column of the next write
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            dst_col_q <= '0;
        else if (wr_go) begin
            if (dst_col_q == upsp_pix_pkg::dst_col_t'(upsp_pix_pkg::DST_WIDTH - 2))
                dst_col_q <= '0;
            else
                dst_col_q <= dst_col_q + step;
        end
    end

    for (genvar j = 0; j < upsp_pix_pkg::N_LANES; j++) begin : g_lane
        upsp_lane_fifo u_fifo (
            .clk   (clk),
            .rst_n (rst_n),
            .wr    (wr_go & wr_mask[j]),
            .rd    (rd_go),
            .wdata (beat.lane[j]),
            .rdata (lane_rdata[j]),
            .empty (lane_empty[j]),
            .full  (lane_full[j])
        );
    end

    // Lanes 0 and 1 lead each word, lanes 2 and 3 follow
    always_comb begin
        for (int k = 0; k < upsp_pix_pkg::N_LANES; k++) begin
            rd_word.slot[k] = lane_rdata[k];
        end
    end

endmodule

// ==== source/upsp_pix_pkg.sv ====
/* Pixel types and frame geometry */

package upsp_pix_pkg;

    // Source frame size, width even and at least 4
    localparam int SRC_WIDTH  = 8;
    localparam int SRC_HEIGHT = 4;

    // Each source row doubles horizontally
    localparam int DST_WIDTH  = 2 * SRC_WIDTH;

    // Pixels carried by one beat or one read word
    localparam int N_LANES    = 4;

    typedef logic [7:0] chan_t;

    typedef struct packed {
        chan_t r;
        chan_t g;
        chan_t b;
    } pix_t;

    // Slot 0 holds the oldest destination pixel
    typedef struct packed {
        pix_t [N_LANES-1:0] slot;
    } word_t;

    typedef logic [$clog2(SRC_WIDTH)-1:0]  col_t;
    typedef logic [$clog2(SRC_HEIGHT)-1:0] row_t;
    typedef logic [$clog2(DST_WIDTH)-1:0]  dst_col_t;

endpackage

// ==== source/upsp_top.sv ====
/* Horizontal 2x up-sampler */

`timescale 1ns/1ns

module upsp_top (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                pix_valid,
    input  upsp_pix_pkg::pix_t  pix_in,
    output logic                pix_ready,
    input  logic                rd,
    output upsp_pix_pkg::word_t rd_word,
    output logic                buf_empty
);

    upsp_pix_pkg::col_t        col;
    upsp_ctl_pkg::line_state_t state;
    upsp_ctl_pkg::beat_t       beat;
    logic                      accept;
    logic                      tail;
    logic                      is_last_col;
    logic                      beat_valid;
    logic                      beat_pending;
    logic                      buf_wready;

    upsp_col_counter u_counter (
        .clk               (clk),
        .rst_n             (rst_n),
        .accept            (accept),
        .col               (col),
        .row               (),
        .is_last_col       (is_last_col),
        .is_last_frame_col ()
    );

    upsp_line_fsm u_fsm (
        .clk          (clk),
        .rst_n        (rst_n),
        .pix_valid    (pix_valid),
        .beat_pending (beat_pending),
        .buf_wready   (buf_wready),
        .is_last_col  (is_last_col),
        .col          (col),
        .accept       (accept),
        .pix_ready    (pix_ready),
        .tail         (tail),
        .state        (state)
    );

    upsp_interp u_interp (
        .clk          (clk),
        .rst_n        (rst_n),
        .accept       (accept),
        .tail         (tail),
        .state        (state),
        .col          (col),
        .pix_in       (pix_in),
        .buf_wready   (buf_wready),
        .beat_valid   (beat_valid),
        .beat_pending (beat_pending),
        .beat         (beat)
    );

    upsp_outbuf u_outbuf (
        .clk        (clk),
        .rst_n      (rst_n),
        .beat_valid (beat_valid),
        .beat       (beat),
        .buf_wready (buf_wready),
        .rd         (rd),
        .rd_word    (rd_word),
        .buf_empty  (buf_empty)
    );

endmodule

// ==== tests/tb_upsp.sv ====
/* Up-sampler random testbench */

`timescale 1ns/1ns

module tb_upsp;

    localparam int FRAMES          = 3;
    localparam int PIX_TOTAL       = FRAMES * upsp_pix_pkg::SRC_WIDTH * upsp_pix_pkg::SRC_HEIGHT;
    localparam int WORDS_PER_ROW   = upsp_pix_pkg::DST_WIDTH / upsp_pix_pkg::N_LANES;
    localparam int WORDS_PER_FRAME = WORDS_PER_ROW * upsp_pix_pkg::SRC_HEIGHT;
    localparam int WORDS_TOTAL     = FRAMES * WORDS_PER_FRAME;
    localparam int IN_TIMEOUT      = 20000;
    localparam int DRAIN_TIMEOUT   = 4000;
    localparam int IDLE_BURST      = 40;

    logic                clk;
    logic                rst_n;
    logic                pix_valid;
    upsp_pix_pkg::pix_t  pix_in;
    logic                pix_ready;
    logic                rd;
    upsp_pix_pkg::word_t rd_word;
    logic                buf_empty;

    integer              seed = 32'h047c1087;
    logic [31:0]         rand_word;
    int unsigned         roll;
    int                  idle_left;
    bit                  running;

    // Reference model state
    upsp_pix_pkg::pix_t  row_buf [upsp_pix_pkg::SRC_WIDTH];
    upsp_pix_pkg::word_t exp_q [$];
    upsp_pix_pkg::word_t act_q [$];
    int                  src_col;
    int                  n_accepted;
    int                  n_read;
    int                  n_checked;
    int                  low_run;
    int                  max_low_run;
    int                  cycles;

    upsp_top uut (
        .clk       (clk),
        .rst_n     (rst_n),
        .pix_valid (pix_valid),
        .pix_in    (pix_in),
        .pix_ready (pix_ready),
        .rd        (rd),
        .rd_word   (rd_word),
        .buf_empty (buf_empty)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("SOME TESTS FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_word(input string name, input upsp_pix_pkg::word_t exp,
                              input upsp_pix_pkg::word_t act);
        if (act !== exp)
            abort_run($sformatf("error %s expected %h actual %h", name, exp, act));
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp)
            abort_run($sformatf("error %s expected %b actual %b", name, exp, act));
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp)
            abort_run($sformatf("error %s expected %0d actual %0d", name, exp, act));
    endtask

    // Channel mean rounded down
    function automatic upsp_pix_pkg::pix_t mean_pixel(input upsp_pix_pkg::pix_t a,
                                                      input upsp_pix_pkg::pix_t b);
        upsp_pix_pkg::pix_t m;
        m.r = upsp_pix_pkg::chan_t'((int'(a.r) + int'(b.r)) / 2);
        m.g = upsp_pix_pkg::chan_t'((int'(a.g) + int'(b.g)) / 2);
        m.b = upsp_pix_pkg::chan_t'((int'(a.b) + int'(b.b)) / 2);
        return m;
    endfunction

    function automatic string word_label(input int idx);
        int    pos;
        int    row;
        string kind;
        pos = idx % WORDS_PER_ROW;
        row = idx / WORDS_PER_ROW;
        if (pos == 0)
            kind = "row head word";
        else if (pos == WORDS_PER_ROW - 1)
            kind = "row tail word";
        else
            kind = "row body word";
        return $sformatf("%s frame %0d row %0d", kind, row / upsp_pix_pkg::SRC_HEIGHT,
                         row % upsp_pix_pkg::SRC_HEIGHT);
    endfunction

    // Doubles a finished source row and queues it as read words
    task automatic push_row_words();
        upsp_pix_pkg::pix_t  dst [upsp_pix_pkg::DST_WIDTH];
        upsp_pix_pkg::word_t w;
        for (int i = 0; i < upsp_pix_pkg::SRC_WIDTH; i++) begin
            dst[2*i] = row_buf[i];
            if (i < upsp_pix_pkg::SRC_WIDTH - 1)
                dst[2*i+1] = mean_pixel(row_buf[i], row_buf[i+1]);
            else
                dst[2*i+1] = row_buf[i];
        end
        for (int k = 0; k < WORDS_PER_ROW; k++) begin
            for (int j = 0; j < upsp_pix_pkg::N_LANES; j++)
                w.slot[j] = dst[k*upsp_pix_pkg::N_LANES + j];
            exp_q.push_back(w);
        end
    endtask

    // Stimulus changes just after each rising edge
    always @(posedge clk) begin
        if (!running) begin
            pix_valid <= 1'b0;
            pix_in    <= '0;
            rd        <= 1'b0;
        end else begin
            roll      = {$random(seed)} % 100;
            rand_word = $random(seed);
            pix_valid <= (n_accepted < PIX_TOTAL) && (roll < 70);
            pix_in    <= rand_word[23:0];
            roll      = {$random(seed)} % 100;
            if (idle_left > 0) begin
                rd        <= 1'b0;
                idle_left = idle_left - 1;
            end else if (roll < 2) begin
                // Long read gap fills the lanes
                rd        <= 1'b0;
                idle_left = IDLE_BURST;
            end else begin
                rd <= (roll < 42);
            end
        end
    end

    // Handshakes are stable at the falling edge
    always @(negedge clk) begin
        if (rst_n) begin
            if (pix_valid && pix_ready) begin
                row_buf[src_col] = pix_in;
                src_col          = src_col + 1;
                n_accepted       = n_accepted + 1;
                if (src_col == upsp_pix_pkg::SRC_WIDTH) begin
                    push_row_words();
                    src_col = 0;
                end
            end
            if (rd && !buf_empty) begin
                act_q.push_back(rd_word);
                n_read = n_read + 1;
            end
            if (running && !pix_ready) begin
                low_run = low_run + 1;
                if (low_run > max_low_run)
                    max_low_run = low_run;
            end else begin
                low_run = 0;
            end
            while (exp_q.size() > 0 && act_q.size() > 0) begin
                check_word(word_label(n_checked), exp_q.pop_front(), act_q.pop_front());
                n_checked = n_checked + 1;
            end
        end
    end

    initial begin
        rst_n       = 1'b0;
        pix_valid   = 1'b0;
        pix_in      = '0;
        rd          = 1'b0;
        running     = 1'b0;
        idle_left   = IDLE_BURST;
        src_col     = 0;
        n_accepted  = 0;
        n_read      = 0;
        n_checked   = 0;
        low_run     = 0;
        max_low_run = 0;

        @(posedge clk);
        @(negedge clk);
        check_flag("pix_ready during reset", 1'b0, pix_ready);
        @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        @(negedge clk);
        check_flag("pix_ready after reset", 1'b1, pix_ready);
        check_flag("buf_empty after reset", 1'b1, buf_empty);
        running = 1'b1;

        cycles = 0;
        while (n_accepted < PIX_TOTAL && cycles < IN_TIMEOUT) begin
            @(posedge clk);
            cycles = cycles + 1;
        end
        if (n_accepted < PIX_TOTAL)
            abort_run("timeout while feeding source pixels, input stayed stalled");

        cycles = 0;
        while (n_read < WORDS_TOTAL && cycles < DRAIN_TIMEOUT) begin
            @(posedge clk);
            cycles = cycles + 1;
        end
        if (n_read < WORDS_TOTAL)
            abort_run("timeout while draining the buffer, words are missing");

        // One edge for the last pop to land
        @(posedge clk);
        @(negedge clk);
        check_flag("buf_empty after drain", 1'b1, buf_empty);
        check_count("words read", WORDS_TOTAL, n_read);
        check_flag("pix_ready held low under back-pressure", 1'b1, max_low_run >= 8);

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule
